// File: list.f
uart_pkg.sv
uart_rx.sv
uart_tx.sv
uart_wb8.sv
tb_clkgen.sv
uart_wb8_tb.sv

// File: Bender.yml
package:
  name: uart_wb8

dependencies: {}

sources:
  # package first, then leaf modules, then the top level
  - uart_pkg.sv
  - uart_rx.sv
  - uart_tx.sv
  - uart_wb8.sv

  # testbench
  - target: test
    files:
      - tb_clkgen.sv
      - uart_wb8_tb.sv

# top modules: uart_wb8 (design), uart_wb8_tb (simulation)
# file list for other tools: list.f

// File: uart_wb8_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_wb8_tb import uart_pkg::*; ();

    localparam int ACK_TIMEOUT   = 8;
    localparam int EDGE_TIMEOUT  = 2 * BAUD_CLOCKS;
    localparam int POLL_TIMEOUT  = 12 * BAUD_CLOCKS;  // bus reads
    localparam int FRAME_TIMEOUT = 14 * BAUD_CLOCKS;

    typedef enum {OP_WRITE, OP_READ, OP_POLL, OP_SEND, OP_GLITCH, OP_EXPECT, OP_QUIET} op_e;

    logic       clk;
    logic       rst_n;
    logic [1:0] adr;
    logic [7:0] wdat;
    logic       stb;
    logic       we;
    logic       ack;
    logic [7:0] rdat;
    logic       rx_line;
    logic       tx_line;

    // stimulus table with one entry per index
    string      row_name[$];
    op_e        row_op[$];
    logic [1:0] row_adr[$];
    int         row_data[$];
    logic [7:0] row_exp[$];

    logic [31:0] lfsr_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          monitor_busy;

    tb_clkgen clock_gen (
        .I_wb_clk (clk),
        .rst_n    (rst_n)
    );

    uart_wb8 UUT (
        .I_wb_clk (clk),
        .rst_n    (rst_n),
        .I_wb_adr (adr),
        .I_wb_dat (wdat),
        .I_wb_stb (stb),
        .I_wb_we  (we),
        .O_wb_ack (ack),
        .O_wb_dat (rdat),
        .I_rx     (rx_line),
        .O_tx     (tx_line)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, inout bit ok);
        if (expected !== actual) begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic report_timeout(input string name, input string what, inout bit ok);
        $display("%s: gave up waiting for %s", name, what);
        errors++;
        ok = 1'b0;
    endtask

    task automatic finish_test(input string name, input bit ok);
        tests_run++;
        if (ok) begin
            $display("ok   %s", name);
        end else begin
            tests_failed++;
            $display("bad  %s", name);
        end
    endtask

    task automatic add_row(input string name, input op_e op, input logic [1:0] a,
                           input int data, input logic [7:0] expected);
        row_name.push_back(name);
        row_op.push_back(op);
        row_adr.push_back(a);
        row_data.push_back(data);
        row_exp.push_back(expected);
    endtask

    // one single-cycle strobe with the ack due one cycle later
    task automatic bus_access(input string name, input logic write, input logic [1:0] a,
                              input logic [7:0] d, output logic [7:0] q, inout bit ok);
        int cycles;
        @(negedge clk);
        adr  = a;
        wdat = d;
        we   = write;
        stb  = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            stb = 1'b0;
            we  = 1'b0;
            cycles++;
        end while (ack !== 1'b1 && cycles < ACK_TIMEOUT);
        q = rdat;
        if (ack !== 1'b1) begin
            report_timeout(name, "the bus acknowledge", ok);
        end else begin
            check_value({name, " ack cycles"}, 1, cycles, ok);
        end
    endtask

    task automatic poll_status(input string name, input logic [1:0] a,
                               input logic [7:0] expected, inout bit ok);
        logic [7:0] q;
        int tries;
        tries = 0;
        q = ~expected;
        while (q !== expected && tries < POLL_TIMEOUT && ok) begin
            bus_access(name, 1'b0, a, 8'h00, q, ok);
            tries++;
        end
        if (q !== expected && ok) begin
            report_timeout(name, $sformatf("0x%0h at address %0d", expected, a), ok);
        end
    endtask

    // 8N1 frame sent lsb first
    task automatic send_serial(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx_line = frame[i];
            repeat (BAUD_CLOCKS - 1) @(negedge clk);
        end
    endtask

    task automatic glitch_rx(input int len);
        @(negedge clk);
        rx_line = 1'b0;
        repeat (len) @(negedge clk);
        rx_line = 1'b1;
        repeat (11 * BAUD_CLOCKS) @(negedge clk); // longer than any false frame
    endtask

    task automatic watch_quiet(input int len, output int bad);
        bad = 0;
        repeat (len) begin
            @(negedge clk);
            if (tx_line !== 1'b1 || ack !== 1'b0) begin
                bad++;
            end
        end
    endtask

    task automatic capture_frame(input string name, input logic [7:0] expected);
        logic [7:0] b;
        logic       start_bit;
        logic       stop_bit;
        int         waited;
        bit         ok;
        ok = 1'b1;
        b = '0;
        waited = 0;
        while (tx_line !== 1'b0 && waited < EDGE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_line !== 1'b0) begin
            report_timeout(name, "a start bit on O_tx", ok);
        end else begin
            repeat (BAUD_CLOCKS / 2) @(negedge clk); // middle of start bit
            start_bit = tx_line;
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_CLOCKS) @(negedge clk);
                b[i] = tx_line;
            end
            repeat (BAUD_CLOCKS) @(negedge clk);
            stop_bit = tx_line;
            check_value({name, " start bit"}, 0, start_bit, ok);
            check_value(name, expected, b, ok);
            check_value({name, " stop bit"}, 1, stop_bit, ok);
        end
        finish_test(name, ok);
        monitor_busy = 1'b0;
    endtask

    task automatic wait_monitor(input string name, inout bit ok);
        int waited;
        waited = 0;
        while (monitor_busy && waited < FRAME_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (monitor_busy) begin
            report_timeout(name, "the serial monitor to finish", ok);
        end
    endtask

    task automatic run_row(input string name, input op_e op, input logic [1:0] a,
                           input int data, input logic [7:0] expected);
        logic [7:0] q;
        int         bad;
        bit         ok;
        ok = 1'b1;
        case (op)
            OP_WRITE: bus_access(name, 1'b1, a, data[7:0], q, ok);
            OP_READ: begin
                bus_access(name, 1'b0, a, 8'h00, q, ok);
                if (ok) begin
                    check_value(name, expected, q, ok);
                end
            end
            OP_POLL:   poll_status(name, a, expected, ok);
            OP_SEND:   send_serial(data[7:0]);
            OP_GLITCH: glitch_rx(data);
            OP_QUIET: begin
                watch_quiet(data, bad);
                check_value(name, expected, bad, ok);
            end
            OP_EXPECT: begin
                wait_monitor(name, ok);
                if (ok) begin
                    monitor_busy = 1'b1;
                    fork
                        capture_frame(name, expected);
                    join_none
                end
            end
            default: report_timeout(name, "a known operation", ok);
        endcase
        // the monitor reports its own line
        if (op != OP_EXPECT || !ok) begin
            finish_test(name, ok);
        end
    endtask

    task automatic build_table();
        logic [7:0] rnd [4];
        for (int i = 0; i < 4; i++) begin
            rand_byte(rnd[i]);
        end
        add_row("reset_line_idle", OP_QUIET, 0, 20, 0);
        add_row("reset_rx_status", OP_READ, ADDR_RX_STATUS, 0, 8'h00);
        add_row("reset_tx_status", OP_READ, ADDR_TX_STATUS, 0, 8'h01);
        add_row("reset_tx_status_alt", OP_READ, ADDR_TX_STATUS_ALT, 0, 8'h01);
        add_row("tx_frame_a5", OP_EXPECT, 0, 0, 8'ha5);
        add_row("tx_write_a5", OP_WRITE, ADDR_DATA, 8'ha5, 0);
        add_row("tx_busy_status", OP_READ, ADDR_TX_STATUS, 0, 8'h00);
        add_row("tx_busy_status_alt", OP_READ, ADDR_TX_STATUS_ALT, 0, 8'h00);
        add_row("tx_write_dropped", OP_WRITE, ADDR_DATA, 8'h3c, 0);
        add_row("tx_free_after_a5", OP_POLL, ADDR_TX_STATUS, 0, 8'h01);
        add_row("tx_line_quiet", OP_QUIET, 0, 2 * BAUD_CLOCKS, 0);
        for (int i = 0; i < 2; i++) begin
            add_row($sformatf("tx_frame_rand%0d", i), OP_EXPECT, 0, 0, rnd[i]);
            add_row($sformatf("tx_write_rand%0d", i), OP_WRITE, ADDR_DATA, rnd[i], 0);
            add_row($sformatf("tx_free_rand%0d", i), OP_POLL, ADDR_TX_STATUS, 0, 8'h01);
        end
        add_row("rx_send_5a", OP_SEND, 0, 8'h5a, 0);
        add_row("rx_ready_5a", OP_POLL, ADDR_RX_STATUS, 0, 8'h01);
        add_row("rx_data_5a", OP_READ, ADDR_DATA, 0, 8'h5a);
        add_row("rx_cleared_5a", OP_READ, ADDR_RX_STATUS, 0, 8'h00);
        add_row("rx_send_rand2", OP_SEND, 0, rnd[2], 0);
        add_row("rx_ready_rand2", OP_POLL, ADDR_RX_STATUS, 0, 8'h01);
        add_row("rx_data_rand2", OP_READ, ADDR_DATA, 0, rnd[2]);
        add_row("rx_cleared_rand2", OP_READ, ADDR_RX_STATUS, 0, 8'h00);
        // second byte must replace the unread first one
        add_row("rx_send_first", OP_SEND, 0, ~rnd[3], 0);
        add_row("rx_send_second", OP_SEND, 0, rnd[3], 0);
        add_row("rx_ready_overwrite", OP_POLL, ADDR_RX_STATUS, 0, 8'h01);
        add_row("rx_data_overwrite", OP_READ, ADDR_DATA, 0, rnd[3]);
        add_row("rx_cleared_overwrite", OP_READ, ADDR_RX_STATUS, 0, 8'h00);
        add_row("rx_glitch", OP_GLITCH, 0, 3, 0);
        add_row("rx_status_after_glitch", OP_READ, ADDR_RX_STATUS, 0, 8'h00);
    endtask

    initial begin
        int waited;
        bit ok;
        adr          = '0;
        wdat         = '0;
        stb          = 1'b0;
        we           = 1'b0;
        rx_line      = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        monitor_busy = 1'b0;
        lfsr_state   = 32'h5ff5af05;
        build_table();

        ok = 1'b1;
        waited = 0;
        while (rst_n !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);
        if (rst_n !== 1'b1) begin
            report_timeout("reset_outputs", "reset release", ok);
        end else begin
            check_value("reset_outputs", {1'b0, 8'h00, 1'b1}, {ack, rdat, tx_line}, ok);
        end
        finish_test("reset_outputs", ok);

        for (int i = 0; i < row_name.size(); i++) begin
            run_row(row_name[i], row_op[i], row_adr[i], row_data[i], row_exp[i]);
        end

        ok = 1'b1;
        wait_monitor("end_of_table", ok);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic I_wb_clk,
    output logic rst_n
);

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 4;

    initial begin
        I_wb_clk = 1'b0;
        forever #(PERIOD_NS / 2) I_wb_clk = ~I_wb_clk;
    end

    // released on a falling edge like all other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge I_wb_clk);
        @(negedge I_wb_clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: uart_wb8.sv
`timescale 1ns/100ps
`default_nettype none

module uart_wb8 import uart_pkg::*; (
    input  logic       I_wb_clk,
    input  logic       rst_n,
    input  logic [1:0] I_wb_adr,
    input  logic [7:0] I_wb_dat,
    input  logic       I_wb_stb,
    input  logic       I_wb_we,
    output logic       O_wb_ack,
    output logic [7:0] O_wb_dat,
    input  logic       I_rx,
    output logic       O_tx
);

    reg_addr_e adr;

    logic       rx_valid;
    logic [7:0] rx_data;
    logic [7:0] rx_buf;     // last received byte
    logic       read_ready;

    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;
    logic       tx_free;

    logic       data_wr;
    logic       data_rd;
    logic       bus_rd;
    logic       tx_accept;

    assign adr = reg_addr_e'(I_wb_adr);

    // a start pulse still in flight counts as busy
    assign tx_free = !tx_busy && !tx_start;

    assign bus_rd    = I_wb_stb && !I_wb_we;
    assign data_wr   = I_wb_stb && I_wb_we && (adr == ADDR_DATA);
    assign data_rd   = bus_rd && (adr == ADDR_DATA);
    assign tx_accept = data_wr && tx_free; // otherwise the write is dropped

    uart_rx u_rx (
        .I_wb_clk (I_wb_clk),
        .rst_n    (rst_n),
        .I_rx     (I_rx),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    uart_tx u_tx (
        .I_wb_clk (I_wb_clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .O_tx     (O_tx)
    );

    // single cycle handshake without wait states
    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            O_wb_ack <= 1'b0;
        end else begin
            O_wb_ack <= I_wb_stb;
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            O_wb_dat <= '0;
        end else if (bus_rd) begin
            case (adr)
                ADDR_DATA:      O_wb_dat <= rx_buf;
                ADDR_RX_STATUS: O_wb_dat <= {7'b0, read_ready};
                ADDR_TX_STATUS, ADDR_TX_STATUS_ALT: begin
                    O_wb_dat <= {7'b0, tx_free};
                end
                default:        O_wb_dat <= '0;
            endcase
        end
    end

    // an unread byte is simply overwritten
    always_ff @(posedge I_wb_clk) begin
        if (rx_valid) begin
            rx_buf <= rx_data;
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            read_ready <= 1'b0;
        end else if (rx_valid) begin
            read_ready <= 1'b1; // set beats a read in the same cycle
        end else if (data_rd) begin
            read_ready <= 1'b0;
        end
    end

    // transmit side
    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            tx_start <= 1'b0;
        end else begin
            tx_start <= tx_accept;
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (tx_accept) begin
            tx_data <= I_wb_dat;
        end
    end

    ack_follows_stb: assert property (
        @(posedge I_wb_clk) disable iff (!rst_n)
        1'b1 |=> (O_wb_ack == $past(I_wb_stb))
    );

    // accepted write shows its start bit two cycles later
    start_bit_latency: assert property (
        @(posedge I_wb_clk) disable iff (!rst_n)
        tx_accept |-> ##2 !O_tx
    );

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic       I_wb_clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx_busy,
    output logic       O_tx
);

    tx_state_e state;

    logic [BAUD_CNT_W-1:0] clk_cnt;
    logic [3:0]            bit_cnt; // bit period being sent, 0 is start
    logic [7:0]            shift;
    logic                  bit_end;
    logic                  load;

    assign bit_end = (clk_cnt == BAUD_CNT_W'(BAUD_CLOCKS - 1));
    assign load    = (state == TX_IDLE) && tx_start;
    assign tx_busy = (state == TX_WRITE);

    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            O_tx    <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    O_tx <= 1'b1; // line idles high
                    if (tx_start) begin
                        state   <= TX_WRITE;
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        O_tx    <= 1'b0; // start bit
                    end
                end

                TX_WRITE: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 4'd1;
                        O_tx    <= shift[0];
                        if (bit_cnt == 4'd9) begin
                            state <= TX_IDLE; // stop bit has run its full time
                        end
                    end
                end

                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // ones shift in behind the data and become the stop bit
    always_ff @(posedge I_wb_clk) begin
        if (load) begin
            shift <= tx_data;
        end else if (tx_busy && bit_end) begin
            shift <= {1'b1, shift[7:1]};
        end
    end

    idle_line_high: assert property (
        @(posedge I_wb_clk) disable iff (!rst_n)
        (state == TX_IDLE && !tx_start) |-> O_tx
    );

    no_start_when_busy: assert property (
        @(posedge I_wb_clk) disable iff (!rst_n)
        tx_busy |-> !tx_start
    );

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  logic       I_wb_clk,
    input  logic       rst_n,
    input  logic       I_rx,
    output logic       rx_valid,
    output logic [7:0] rx_data
);

    rx_state_e state;

    logic [2:0]            filter;  // newest sample at bit 2
    logic [BAUD_CNT_W-1:0] clk_cnt;
    logic [3:0]            bit_cnt; // 0 start bit, 1..8 data, 9 stop
    logic [7:0]            shift;
    logic                  mid_bit;
    logic                  bit_end;
    logic                  start_seen;
    logic                  data_bit;

    assign mid_bit = (clk_cnt == BAUD_CNT_W'(BAUD_CLOCKS / 2));
    assign bit_end = (clk_cnt == BAUD_CNT_W'(BAUD_CLOCKS - 1));

    // line low now and for the three samples before
    assign start_seen = ({I_rx, filter} == 4'b0000);

    assign data_bit = (bit_cnt != 4'd0) && (bit_cnt != 4'd9);

    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            filter   <= 3'b111;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;

            case (state)
                RX_IDLE: begin
                    filter <= {I_rx, filter[2:1]};
                    if (start_seen) begin
                        state   <= RX_READ;
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        filter  <= 3'b111; // ready for the next frame
                    end
                end

                RX_READ: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end

                    if (mid_bit) begin
                        if (bit_cnt == 4'd9) begin
                            // stop bit reached so the byte is complete
                            rx_valid <= 1'b1;
                            state    <= RX_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end

                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // byte assembly with the lsb arriving first
    always_ff @(posedge I_wb_clk) begin
        if (state == RX_READ && mid_bit && data_bit) begin
            shift <= {I_rx, shift[7:1]};
        end
    end

    assign rx_data = shift; // stable from the stop bit until the next frame

    bit_cnt_in_range: assert property (
        @(posedge I_wb_clk) disable iff (!rst_n)
        (state == RX_READ) |-> (bit_cnt <= 4'd9)
    );

endmodule

`default_nettype wire

// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

    // clock and line rate, fixed at build time
    localparam int CLOCKFREQ = 25000000;               // bus clock in hertz
    localparam int BAUDRATE = 115200;
    localparam int BAUD_CLOCKS = CLOCKFREQ / BAUDRATE; // 217 cycles per bit

    localparam int BAUD_CNT_W = 10;                    // holds up to 1023 cycles

    // register map of the bus slave
    typedef enum logic [1:0] {
        ADDR_DATA          = 2'd0, // tx on write, rx buffer on read
        ADDR_RX_STATUS     = 2'd1, // bit 0 byte ready
        ADDR_TX_STATUS     = 2'd2, // bit 0 transmitter free
        ADDR_TX_STATUS_ALT = 2'd3  // mirror of send status
    } reg_addr_e;

    // receiver FSM
    typedef enum logic {
        RX_IDLE = 1'b0,
        RX_READ = 1'b1
    } rx_state_e;

    // transmitter FSM
    typedef enum logic {
        TX_IDLE  = 1'b0,
        TX_WRITE = 1'b1
    } tx_state_e;

endpackage

`default_nettype wire
